// File: include/pipe_defines.svh
// width and size macros for the in-order integer pipeline
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

////////////////////
// datapath sizes
////////////////////

// data word width, rv32
`define PIPE_XLEN 32

// architectural integer registers, x0 included
`define PIPE_NREGS 32

// bits needed to name one register
`define PIPE_REG_IDX_W 5

// width of the completed-instruction counter
`define PIPE_RETIRED_W 16

`endif

// File: logic/isa_pkg.sv
// rv32i subset types: opcodes, funct fields, alu operations, error codes
`include "pipe_defines.svh"

package isa_pkg;

    ////////////////////
    // instruction fields
    ////////////////////

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes handled by decode
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // funct3 groups, shared by OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct7 values, alt selects sub and sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // the only SYSTEM word accepted
    localparam logic [`PIPE_XLEN-1:0] WFI_WORD = 32'h1050_0073;

    ////////////////////
    // enums
    ////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // also the state of the commit error machine
    typedef enum logic [1:0] {
        NO_ERROR,
        ILLEGAL_INST,
        HALTED_ON_WFI
    } error_code_e;

endpackage

// File: logic/pipe_pkg.sv
// datapath types: word, register index, busy mask, retired count
`include "pipe_defines.svh"

package pipe_pkg;

    ////////////////////
    // datapath types
    ////////////////////

    // operand or result value
    typedef logic [`PIPE_XLEN-1:0] word_t;

    // architectural register number
    typedef logic [`PIPE_REG_IDX_W-1:0] reg_idx_t;

    // one busy flag per register, bit n for xn
    typedef logic [`PIPE_NREGS-1:0] busy_mask_t;

    // completed-instruction count, wraps
    typedef logic [`PIPE_RETIRED_W-1:0] retired_t;

    // hardwired zero register
    localparam reg_idx_t REG_ZERO = '0;

endpackage

// File: logic/register_file.sv
// integer register file, two read ports, one write port, write-through bypass
`timescale 1ns/1ps
`include "pipe_defines.svh"

module register_file (
    input  logic               clock,
    input  logic               rst_n,
    input  pipe_pkg::reg_idx_t rd_idx_a,
    input  pipe_pkg::reg_idx_t rd_idx_b,
    output pipe_pkg::word_t    rd_data_a,
    output pipe_pkg::word_t    rd_data_b,
    input  logic               wr_en,
    input  pipe_pkg::reg_idx_t wr_idx,
    input  pipe_pkg::word_t    wr_data
);

    // storage for x1 .. x31 only
    pipe_pkg::word_t regs [1:`PIPE_NREGS-1];

    // one read port
    // x0 first, then the write in flight, then storage
    function automatic pipe_pkg::word_t read_port(input pipe_pkg::reg_idx_t idx);
        pipe_pkg::word_t value;
        if (idx == pipe_pkg::REG_ZERO) begin
            value = '0;
        end else if (wr_en && wr_idx == idx) begin
            value = wr_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    // follows the write port and storage as well as the indices
    always_comb begin
        rd_data_a = read_port(rd_idx_a);
        rd_data_b = read_port(rd_idx_b);
    end

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `PIPE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != pipe_pkg::REG_ZERO) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: logic/decode_stage.sv
// decode, operand read, scoreboard stall, halt latch, decode/execute register
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  pipe_pkg::word_t       inst,
    output logic                  stall,
    output pipe_pkg::reg_idx_t    rf_idx_a,
    output pipe_pkg::reg_idx_t    rf_idx_b,
    input  pipe_pkg::word_t       rf_data_a,
    input  pipe_pkg::word_t       rf_data_b,
    input  logic                  release_en,
    input  pipe_pkg::reg_idx_t    release_idx,
    output logic                  dx_valid,
    output isa_pkg::alu_op_e      dx_alu_op,
    output pipe_pkg::word_t       dx_opa,
    output pipe_pkg::word_t       dx_opb,
    output pipe_pkg::reg_idx_t    dx_rd,
    output logic                  dx_write,
    output isa_pkg::error_code_e  dx_error
);

    // instruction fields
    isa_pkg::opcode_t   opcode;
    isa_pkg::funct3_t   funct3;
    isa_pkg::funct7_t   funct7;
    pipe_pkg::reg_idx_t rd;
    pipe_pkg::reg_idx_t rs1;
    pipe_pkg::reg_idx_t rs2;
    pipe_pkg::word_t    imm_i;
    pipe_pkg::word_t    imm_u;

    // decoded controls
    isa_pkg::alu_op_e     alu_op;
    isa_pkg::error_code_e err;
    pipe_pkg::word_t      opb;
    logic                 use_rs1;
    logic                 use_rs2;
    logic                 writes_rd;

    // scoreboard
    pipe_pkg::busy_mask_t busy_q;
    pipe_pkg::busy_mask_t busy_eff;
    pipe_pkg::busy_mask_t release_mask;
    pipe_pkg::busy_mask_t set_mask;
    logic                 halt_q;
    logic                 take;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_u  = {inst[31:12], 12'b0};

    // ports always read the rs fields
    assign rf_idx_a = rs1;
    assign rf_idx_b = rs2;

    // funct3 to alu op, alt picks sub or sra
    function automatic isa_pkg::alu_op_e alu_sel(input isa_pkg::funct3_t f3, input logic alt);
        isa_pkg::alu_op_e op;
        case (f3)
            isa_pkg::F3_ADD:  op = alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:  op = isa_pkg::ALU_SLL;
            isa_pkg::F3_SLT:  op = isa_pkg::ALU_SLT;
            isa_pkg::F3_SLTU: op = isa_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:  op = isa_pkg::ALU_XOR;
            isa_pkg::F3_SR:   op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:   op = isa_pkg::ALU_OR;
            default:          op = isa_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    ////////////////////
    // decode
    ////////////////////

    always_comb begin
        alu_op    = isa_pkg::ALU_ADD;
        opb       = imm_u;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        err       = isa_pkg::ILLEGAL_INST;
        case (opcode)
            isa_pkg::OPC_OP: begin
                // alt funct7 only valid with add and shift-right
                if (funct7 == isa_pkg::F7_BASE ||
                    (funct7 == isa_pkg::F7_ALT &&
                     (funct3 == isa_pkg::F3_ADD || funct3 == isa_pkg::F3_SR))) begin
                    alu_op    = alu_sel(funct3, funct7 == isa_pkg::F7_ALT);
                    opb       = rf_data_b;
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    writes_rd = 1'b1;
                    err       = isa_pkg::NO_ERROR;
                end
            end
            isa_pkg::OPC_OP_IMM: begin
                // funct7 only matters for the shift immediates
                if ((funct3 != isa_pkg::F3_SLL && funct3 != isa_pkg::F3_SR) ||
                    funct7 == isa_pkg::F7_BASE ||
                    (funct3 == isa_pkg::F3_SR && funct7 == isa_pkg::F7_ALT)) begin
                    alu_op    = alu_sel(funct3,
                                        funct3 == isa_pkg::F3_SR && funct7 == isa_pkg::F7_ALT);
                    opb       = imm_i;
                    use_rs1   = 1'b1;
                    writes_rd = 1'b1;
                    err       = isa_pkg::NO_ERROR;
                end
            end
            isa_pkg::OPC_LUI: begin
                alu_op    = isa_pkg::ALU_PASS_B;
                writes_rd = 1'b1;
                err       = isa_pkg::NO_ERROR;
            end
            isa_pkg::OPC_SYSTEM: begin
                if (inst == isa_pkg::WFI_WORD) begin
                    err = isa_pkg::HALTED_ON_WFI;
                end
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // scoreboard and stall
    ////////////////////

    // release this cycle frees the register for the offered instruction
    assign release_mask = release_en ? (pipe_pkg::busy_mask_t'(1) << release_idx) : '0;
    assign busy_eff     = busy_q & ~release_mask;

    assign stall = halt_q ||
                   (inst_valid && ((use_rs1 && busy_eff[rs1]) ||
                                   (use_rs2 && busy_eff[rs2]) ||
                                   (writes_rd && busy_eff[rd])));
    assign take  = inst_valid && !stall;

    // bit 0 masked, x0 never busy
    assign set_mask = (take && writes_rd) ?
                      ((pipe_pkg::busy_mask_t'(1) << rd) & ~pipe_pkg::busy_mask_t'(1)) : '0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= '0;
            halt_q   <= 1'b0;
            dx_valid <= 1'b0;
        end else begin
            busy_q   <= busy_eff | set_mask;
            dx_valid <= take;
            // sticky until reset
            if (take && err != isa_pkg::NO_ERROR) begin
                halt_q <= 1'b1;
            end
        end
    end

    // decode/execute payload
    always_ff @(posedge clock) begin
        if (take) begin
            dx_alu_op <= alu_op;
            dx_opa    <= rf_data_a;
            dx_opb    <= opb;
            dx_rd     <= rd;
            dx_write  <= writes_rd && rd != pipe_pkg::REG_ZERO;
            dx_error  <= err;
        end
    end

endmodule

// File: logic/execute_stage.sv
// integer alu and the execute/commit register
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  dx_valid,
    input  isa_pkg::alu_op_e      dx_alu_op,
    input  pipe_pkg::word_t       dx_opa,
    input  pipe_pkg::word_t       dx_opb,
    input  pipe_pkg::reg_idx_t    dx_rd,
    input  logic                  dx_write,
    input  isa_pkg::error_code_e  dx_error,
    output logic                  xc_valid,
    output pipe_pkg::word_t       xc_result,
    output pipe_pkg::reg_idx_t    xc_rd,
    output logic                  xc_write,
    output isa_pkg::error_code_e  xc_error
);

    pipe_pkg::word_t alu_result;
    logic [4:0]      shamt;

    // shift amount from the low bits of b
    assign shamt = dx_opb[4:0];

    ////////////////////
    // alu
    ////////////////////

    always_comb begin
        case (dx_alu_op)
            isa_pkg::ALU_ADD:  alu_result = dx_opa + dx_opb;
            isa_pkg::ALU_SUB:  alu_result = dx_opa - dx_opb;
            isa_pkg::ALU_SLL:  alu_result = dx_opa << shamt;
            isa_pkg::ALU_SRL:  alu_result = dx_opa >> shamt;
            isa_pkg::ALU_SRA:  alu_result = pipe_pkg::word_t'($signed(dx_opa) >>> shamt);
            isa_pkg::ALU_XOR:  alu_result = dx_opa ^ dx_opb;
            isa_pkg::ALU_OR:   alu_result = dx_opa | dx_opb;
            isa_pkg::ALU_AND:  alu_result = dx_opa & dx_opb;
            // compares give 0 or 1
            isa_pkg::ALU_SLT: begin
                alu_result = pipe_pkg::word_t'($signed(dx_opa) < $signed(dx_opb));
            end
            isa_pkg::ALU_SLTU: begin
                alu_result = pipe_pkg::word_t'(dx_opa < dx_opb);
            end
            // lui, b already holds the upper immediate
            default:           alu_result = dx_opb;
        endcase
    end

    ////////////////////
    // execute/commit register
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xc_valid <= 1'b0;
        end else begin
            xc_valid <= dx_valid;
        end
    end

    // result and tags
    always_ff @(posedge clock) begin
        if (dx_valid) begin
            xc_result <= alu_result;
            xc_rd     <= dx_rd;
            xc_write  <= dx_write;
            xc_error  <= dx_error;
        end
    end

endmodule

// File: logic/commit_stage.sv
// commit write outputs, retired counter, error status machine
`timescale 1ns/1ps

module commit_stage (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  xc_valid,
    input  pipe_pkg::word_t       xc_result,
    input  pipe_pkg::reg_idx_t    xc_rd,
    input  logic                  xc_write,
    input  isa_pkg::error_code_e  xc_error,
    output logic                  commit_wr_en,
    output pipe_pkg::reg_idx_t    commit_wr_idx,
    output pipe_pkg::word_t       commit_wr_data,
    output pipe_pkg::retired_t    completed_insts,
    output isa_pkg::error_code_e  error_status
);

    // high in the retire cycle
    logic                 retire_q;
    isa_pkg::error_code_e error_next;

    ////////////////////
    // error fsm
    ////////////////////

    // leaves NO_ERROR once, then holds
    always_comb begin
        error_next = error_status;
        case (error_status)
            isa_pkg::NO_ERROR: begin
                if (xc_valid) begin
                    error_next = xc_error;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            commit_wr_en    <= 1'b0;
            retire_q        <= 1'b0;
            completed_insts <= '0;
            error_status    <= isa_pkg::NO_ERROR;
        end else begin
            // x0 writes already dropped by decode
            commit_wr_en    <= xc_valid && xc_write;
            retire_q        <= xc_valid;
            // counts one cycle behind retirement
            completed_insts <= completed_insts + pipe_pkg::retired_t'(retire_q);
            error_status    <= error_next;
        end
    end

    // write payload
    always_ff @(posedge clock) begin
        if (xc_valid && xc_write) begin
            commit_wr_idx  <= xc_rd;
            commit_wr_data <= xc_result;
        end
    end

endmodule

// File: logic/core_pipeline.sv
// core top: decode, execute, commit and the register file
`timescale 1ns/1ps

module core_pipeline (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  pipe_pkg::word_t       inst,
    output logic                  stall,
    output logic                  commit_wr_en,
    output pipe_pkg::reg_idx_t    commit_wr_idx,
    output pipe_pkg::word_t       commit_wr_data,
    output pipe_pkg::retired_t    completed_insts,
    output isa_pkg::error_code_e  error_status
);

    // register file read side
    pipe_pkg::reg_idx_t   rf_idx_a;
    pipe_pkg::reg_idx_t   rf_idx_b;
    pipe_pkg::word_t      rf_data_a;
    pipe_pkg::word_t      rf_data_b;

    // decode to execute
    logic                 dx_valid;
    isa_pkg::alu_op_e     dx_alu_op;
    pipe_pkg::word_t      dx_opa;
    pipe_pkg::word_t      dx_opb;
    pipe_pkg::reg_idx_t   dx_rd;
    logic                 dx_write;
    isa_pkg::error_code_e dx_error;

    // execute to commit
    logic                 xc_valid;
    pipe_pkg::word_t      xc_result;
    pipe_pkg::reg_idx_t   xc_rd;
    logic                 xc_write;
    isa_pkg::error_code_e xc_error;

    // commit write goes back to the file and the scoreboard
    register_file u_register_file (
        .clock(clock), .rst_n(rst_n),
        .rd_idx_a(rf_idx_a), .rd_idx_b(rf_idx_b),
        .rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
        .wr_en(commit_wr_en), .wr_idx(commit_wr_idx), .wr_data(commit_wr_data)
    );

    decode_stage u_decode_stage (
        .clock(clock), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst(inst), .stall(stall),
        .rf_idx_a(rf_idx_a), .rf_idx_b(rf_idx_b),
        .rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
        .release_en(commit_wr_en), .release_idx(commit_wr_idx),
        .dx_valid(dx_valid), .dx_alu_op(dx_alu_op), .dx_opa(dx_opa), .dx_opb(dx_opb),
        .dx_rd(dx_rd), .dx_write(dx_write), .dx_error(dx_error)
    );

    execute_stage u_execute_stage (
        .clock(clock), .rst_n(rst_n),
        .dx_valid(dx_valid), .dx_alu_op(dx_alu_op), .dx_opa(dx_opa), .dx_opb(dx_opb),
        .dx_rd(dx_rd), .dx_write(dx_write), .dx_error(dx_error),
        .xc_valid(xc_valid), .xc_result(xc_result), .xc_rd(xc_rd),
        .xc_write(xc_write), .xc_error(xc_error)
    );

    commit_stage u_commit_stage (
        .clock(clock), .rst_n(rst_n),
        .xc_valid(xc_valid), .xc_result(xc_result), .xc_rd(xc_rd),
        .xc_write(xc_write), .xc_error(xc_error),
        .commit_wr_en(commit_wr_en), .commit_wr_idx(commit_wr_idx),
        .commit_wr_data(commit_wr_data), .completed_insts(completed_insts),
        .error_status(error_status)
    );

endmodule

// File: bench/core_pipeline_tb.sv
// testbench for the core pipeline: stimulus, reference model, compare process, watchdog
`timescale 1ns/1ps
`include "pipe_defines.svh"

module core_pipeline_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RESETS   = 3;
    localparam int RANDOM_INSTS = 300;
    // directed sequences stay under this count
    localparam int DIRECTED_MAX = 40;
    // three stage edges, counter lag, some margin
    localparam int DRAIN_CYCLES = 6;
    localparam int HOLD_CYCLES  = 12;
    localparam int WATCHDOG_NS  = (RANDOM_INSTS + DIRECTED_MAX) * 8 * CLK_PERIOD
                                  + NUM_RESETS * RESET_CYCLES * CLK_PERIOD;

    logic                 clock;
    logic                 rst_n;
    logic                 inst_valid;
    pipe_pkg::word_t      inst;
    logic                 stall;
    logic                 commit_wr_en;
    pipe_pkg::reg_idx_t   commit_wr_idx;
    pipe_pkg::word_t      commit_wr_data;
    pipe_pkg::retired_t   completed_insts;
    isa_pkg::error_code_e error_status;

    // model state and expected writes, oldest first
    pipe_pkg::word_t    model_regs [`PIPE_NREGS];
    pipe_pkg::reg_idx_t exp_idx [$];
    pipe_pkg::word_t    exp_data [$];
    logic [31:0]        rng_state;
    int                 taken_count;
    int                 value_errors;
    int                 other_errors;

    core_pipeline dut (
        .clock(clock), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst(inst), .stall(stall),
        .commit_wr_en(commit_wr_en), .commit_wr_idx(commit_wr_idx),
        .commit_wr_data(commit_wr_data), .completed_insts(completed_insts),
        .error_status(error_status)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic pipe_pkg::word_t encode_op(input logic [6:0] f7,
                                                  input pipe_pkg::reg_idx_t rs2,
                                                  input pipe_pkg::reg_idx_t rs1,
                                                  input logic [2:0] f3,
                                                  input pipe_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic pipe_pkg::word_t encode_op_imm(input logic [11:0] imm,
                                                      input pipe_pkg::reg_idx_t rs1,
                                                      input logic [2:0] f3,
                                                      input pipe_pkg::reg_idx_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic pipe_pkg::word_t encode_lui(input logic [19:0] upper,
                                                   input pipe_pkg::reg_idx_t rd);
        return {upper, rd, 7'b0110111};
    endfunction

    // random OP or OP-IMM over x0..x4, dependences come often
    function automatic pipe_pkg::word_t random_inst(input logic [31:0] r1, input logic [31:0] r2);
        logic [2:0]         f3;
        logic               alt;
        logic [11:0]        imm;
        pipe_pkg::reg_idx_t rd;
        pipe_pkg::reg_idx_t rs1;
        pipe_pkg::reg_idx_t rs2;
        pipe_pkg::word_t    w;
        f3  = r1[2:0];
        alt = r1[3];
        rd  = pipe_pkg::reg_idx_t'(r1[15:8] % 8'd5);
        rs1 = pipe_pkg::reg_idx_t'(r1[23:16] % 8'd5);
        rs2 = pipe_pkg::reg_idx_t'(r1[31:24] % 8'd5);
        if (r1[4]) begin
            // sub and sra only
            w = encode_op((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
        end else begin
            if (f3 == 3'd1) begin
                imm = {7'h00, r2[4:0]};
            end else if (f3 == 3'd5) begin
                imm = {alt ? 7'h20 : 7'h00, r2[4:0]};
            end else begin
                imm = r2[11:0];
            end
            w = encode_op_imm(imm, rs1, f3, rd);
        end
        return w;
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // result of one OP, OP-IMM or LUI word on the model registers
    function automatic pipe_pkg::word_t reference_result(input pipe_pkg::word_t w);
        pipe_pkg::word_t a;
        pipe_pkg::word_t b;
        pipe_pkg::word_t r;
        logic [4:0]      sh;
        logic            is_op;
        is_op = (w[6:0] == 7'b0110011);
        a     = model_regs[w[19:15]];
        b     = is_op ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh    = b[4:0];
        if (w[6:0] == 7'b0110111) begin
            r = {w[31:12], 12'h000};
        end else begin
            case (w[14:12])
                3'd0: r = (is_op && w[30]) ? a - b : a + b;
                3'd1: r = a << sh;
                3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: r = (a < b) ? 32'd1 : 32'd0;
                3'd4: r = a ^ b;
                // bit 30 picks arithmetic for both forms
                3'd5: r = w[30] ? pipe_pkg::word_t'($signed(a) >>> sh) : a >> sh;
                3'd6: r = a | b;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    task automatic record_taken(input pipe_pkg::word_t w);
        pipe_pkg::word_t    res;
        pipe_pkg::reg_idx_t rd;
        rd = w[11:7];
        taken_count++;
        if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011 || w[6:0] == 7'b0110111) begin
            res = reference_result(w);
            // x0 writes vanish
            if (rd != 5'd0) begin
                model_regs[rd] = res;
                exp_idx.push_back(rd);
                exp_data.push_back(res);
            end
        end
    endtask

    ////////////////////
    // checks
    ////////////////////

    task automatic check_value(input string name, input pipe_pkg::word_t actual,
                               input pipe_pkg::word_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED: %s got 0x%h expected 0x%h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    // pops one expected write per commit
    initial begin
        pipe_pkg::reg_idx_t want_idx;
        pipe_pkg::word_t    want_data;
        forever begin
            @(negedge clock);
            if (rst_n && commit_wr_en) begin
                if (exp_idx.size() == 0) begin
                    report_problem("commit write appeared with no write expected");
                end else begin
                    want_idx  = exp_idx.pop_front();
                    want_data = exp_data.pop_front();
                    check_value("commit_wr_idx", 32'(commit_wr_idx), 32'(want_idx));
                    check_value("commit_wr_data", commit_wr_data, want_data);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: pipeline did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // stimulus tasks
    ////////////////////

    // returns just after a rising edge, outputs checked at idle
    task automatic apply_reset();
        @(posedge clock);
        rst_n      <= 1'b0;
        inst_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        exp_idx.delete();
        exp_data.delete();
        taken_count = 0;
        @(negedge clock);
        check_value("commit_wr_en", 32'(commit_wr_en), 32'd0);
        check_value("stall", 32'(stall), 32'd0);
        check_value("completed_insts", 32'(completed_insts), 32'd0);
        check_value("error_status", 32'(error_status), 32'(isa_pkg::NO_ERROR));
        @(posedge clock);
    endtask

    // offer one word and hold it until an edge with stall low
    task automatic issue_inst(input pipe_pkg::word_t w);
        logic taken;
        taken = 1'b0;
        inst_valid <= 1'b1;
        inst       <= w;
        while (!taken) begin
            @(negedge clock);
            taken = !stall;
            @(posedge clock);
        end
        record_taken(w);
    endtask

    task automatic drain_and_check();
        inst_valid <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clock);
        @(negedge clock);
        if (exp_idx.size() != 0) begin
            report_problem("expected writes never committed");
        end
        check_value("completed_insts", 32'(completed_insts), 32'(taken_count) & 32'h0000_FFFF);
        @(posedge clock);
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        rst_n        <= 1'b0;
        inst_valid   <= 1'b0;
        inst         <= '0;
        rng_state    = 32'd19151;
        taken_count  = 0;
        value_errors = 0;
        other_errors = 0;
        apply_reset();

        // random dependent traffic
        for (int i = 0; i < RANDOM_INSTS; i++) begin
            rng_state = xorshift32(rng_state);
            r1        = rng_state;
            rng_state = xorshift32(rng_state);
            r2        = rng_state;
            issue_inst(random_inst(r1, r2));
        end
        drain_and_check();

        // edge operands: zero, all ones, sign bit
        issue_inst(encode_lui(20'h80000, 5'd1));
        issue_inst(encode_op_imm(12'hFFF, 5'd0, 3'd0, 5'd2));
        issue_inst(encode_op_imm(12'h000, 5'd0, 3'd0, 5'd3));
        issue_inst(encode_op_imm(12'h01F, 5'd2, 3'd1, 5'd4));
        issue_inst(encode_op_imm(12'h01F, 5'd1, 3'd5, 5'd5));
        issue_inst(encode_op_imm(12'h41F, 5'd1, 3'd5, 5'd6));
        issue_inst(encode_op_imm(12'h400, 5'd2, 3'd5, 5'd7));
        issue_inst(encode_op_imm(12'h005, 5'd3, 3'd1, 5'd8));
        issue_inst(encode_op_imm(12'h000, 5'd1, 3'd2, 5'd9));
        issue_inst(encode_op_imm(12'hFFF, 5'd2, 3'd3, 5'd10));
        issue_inst(encode_op_imm(12'h001, 5'd3, 3'd3, 5'd11));
        issue_inst(encode_op_imm(12'hFFF, 5'd2, 3'd2, 5'd12));
        issue_inst(encode_op_imm(12'h800, 5'd3, 3'd2, 5'd13));
        // x0 targets retire without a write
        issue_inst(encode_lui(20'hABCDE, 5'd0));
        issue_inst(encode_op_imm(12'h005, 5'd2, 3'd0, 5'd0));
        issue_inst(encode_op_imm(12'h404, 5'd1, 3'd5, 5'd0));
        issue_inst(encode_lui(20'hFFFFF, 5'd14));
        issue_inst(encode_op_imm(12'hFFF, 5'd14, 3'd4, 5'd15));
        issue_inst(encode_op_imm(12'h7FF, 5'd1, 3'd3, 5'd16));
        drain_and_check();

        // illegal word stops the pipe
        apply_reset();
        issue_inst(encode_op_imm(12'h005, 5'd0, 3'd0, 5'd1));
        issue_inst(encode_op_imm(12'h007, 5'd1, 3'd0, 5'd2));
        issue_inst(encode_op(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
        issue_inst(32'hFFFF_FFFF);
        inst       <= encode_op_imm(12'h009, 5'd0, 3'd0, 5'd4);
        inst_valid <= 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clock);
            check_value("stall", 32'(stall), 32'd1);
        end
        @(posedge clock);
        drain_and_check();
        @(negedge clock);
        check_value("error_status", 32'(error_status), 32'(isa_pkg::ILLEGAL_INST));
        check_value("stall", 32'(stall), 32'd1);
        @(posedge clock);

        // wfi halts and still retires
        apply_reset();
        issue_inst(encode_op_imm(12'hFFD, 5'd0, 3'd0, 5'd5));
        issue_inst(encode_op_imm(12'h002, 5'd5, 3'd1, 5'd6));
        issue_inst(32'h1050_0073);
        drain_and_check();
        @(negedge clock);
        check_value("error_status", 32'(error_status), 32'(isa_pkg::HALTED_ON_WFI));
        check_value("stall", 32'(stall), 32'd1);

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/commit_stage.sv
logic/core_pipeline.sv
bench/core_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the core pipeline testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_pipeline_tb -f project.f -o core_pipeline_sim \
    && ./obj_dir/core_pipeline_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log \
    && { echo "simulation reported a failure, see sim.log"; exit 1; } \
    || echo "no failure found in sim.log"
